//--- source/attribute_pkg.sv
// Shared widths, fixed-point formats and fragment structs of the attribute converter
package attribute_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int FLOAT_SIZE       = 32;
    localparam int FIXED_SIZE       = 32;
    localparam int SCREEN_POS_WIDTH = 11;
    localparam int INDEX_WIDTH      = 32;
    localparam int KEEP_WIDTH       = 1;
    localparam int SUB_PIXEL_WIDTH  = 8;

    // Fraction bits of the fixed-point results
    localparam int DEPTH_FRAC = 16;
    localparam int TEX_FRAC   = 15;
    localparam int COLOR_FRAC = 16;

    // Converter latency in clocks
    localparam int CONV_DELAY = 2;

    ////////////////////////////////////////////////////////////
    // Single-precision layout
    ////////////////////////////////////////////////////////////
    localparam int MANT_WIDTH  = 23;
    localparam int EXP_WIDTH   = 8;
    localparam int EXP_BIAS    = 127;
    localparam int SHIFT_WIDTH = 10;

    // Largest left shift of the 24 bit mantissa that still fits below the sign bit
    localparam int MAX_LEFT_SHIFT = FIXED_SIZE - 2 - MANT_WIDTH;

    // Saturation limits
    localparam logic [FIXED_SIZE-1:0] FIXED_MAX = {1'b0, {(FIXED_SIZE - 1){1'b1}}};
    localparam logic [FIXED_SIZE-1:0] FIXED_MIN = {1'b1, {(FIXED_SIZE - 1){1'b0}}};

    ////////////////////////////////////////////////////////////
    // Fragment structs
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [FLOAT_SIZE-1:0] texture_s;
        logic [FLOAT_SIZE-1:0] texture_t;
        logic [FLOAT_SIZE-1:0] mipmap_s;
        logic [FLOAT_SIZE-1:0] mipmap_t;
    } tmu_float_t;

    // All four coordinates in S16.15
    typedef struct packed {
        logic signed [FIXED_SIZE-1:0] texture_s;
        logic signed [FIXED_SIZE-1:0] texture_t;
        logic signed [FIXED_SIZE-1:0] mipmap_s;
        logic signed [FIXED_SIZE-1:0] mipmap_t;
    } tmu_fixed_t;

    typedef struct packed {
        logic [FLOAT_SIZE-1:0] r;
        logic [FLOAT_SIZE-1:0] g;
        logic [FLOAT_SIZE-1:0] b;
        logic [FLOAT_SIZE-1:0] a;
    } color_float_t;

    typedef struct packed {
        logic [SUB_PIXEL_WIDTH-1:0] r;
        logic [SUB_PIXEL_WIDTH-1:0] g;
        logic [SUB_PIXEL_WIDTH-1:0] b;
        logic [SUB_PIXEL_WIDTH-1:0] a;
    } color_fixed_t;

    typedef struct packed {
        logic                          last;
        logic [KEEP_WIDTH-1:0]         keep;
        logic [SCREEN_POS_WIDTH-1:0]   spx;
        logic [SCREEN_POS_WIDTH-1:0]   spy;
        logic [INDEX_WIDTH-1:0]        index;
        logic [FLOAT_SIZE-1:0]         depth_w;
        logic [FLOAT_SIZE-1:0]         depth_z;
        tmu_float_t                    tmu0;
        tmu_float_t                    tmu1;
        color_float_t                  color;
    } fragment_float_t;

    // Depth w stays a float, depth z is Q16.16
    typedef struct packed {
        logic                          last;
        logic [KEEP_WIDTH-1:0]         keep;
        logic [SCREEN_POS_WIDTH-1:0]   spx;
        logic [SCREEN_POS_WIDTH-1:0]   spy;
        logic [INDEX_WIDTH-1:0]        index;
        logic [FLOAT_SIZE-1:0]         depth_w;
        logic signed [FIXED_SIZE-1:0]  depth_z;
        tmu_fixed_t                    tmu0;
        tmu_fixed_t                    tmu1;
        color_fixed_t                  color;
    } fragment_fixed_t;

endpackage

//--- source/float_to_fixed.sv
// Two-stage single-precision to signed fixed-point converter with saturation
`timescale 1ns/1ps

module float_to_fixed
    import attribute_pkg::*;
#(
    parameter int FRAC = 16
)
(
    input  logic                         aclk,
    input  logic [FLOAT_SIZE-1:0]        in_float,
    output logic signed [FIXED_SIZE-1:0] out_fixed
);

    ////////////////////////////////////////////////////////////
    // Stage 1 unpack and classify
    ////////////////////////////////////////////////////////////
    logic                          sign_d;
    logic [EXP_WIDTH-1:0]          exp_d;
    logic [MANT_WIDTH:0]           mant_d;
    logic signed [SHIFT_WIDTH-1:0] shift_d;
    logic                          overflow_d;
    logic                          zero_d;

    assign sign_d = in_float[FLOAT_SIZE-1];
    assign exp_d  = in_float[FLOAT_SIZE-2 -: EXP_WIDTH];

    // Hidden one restored
    assign mant_d = {1'b1, in_float[MANT_WIDTH-1:0]};

    // Position of the binary point relative to the mantissa LSB
    assign shift_d = $signed({{(SHIFT_WIDTH - EXP_WIDTH){1'b0}}, exp_d})
                   - SHIFT_WIDTH'(EXP_BIAS + MANT_WIDTH - FRAC);

    // Infinity and NaN saturate like any value too large for the result
    assign overflow_d = (exp_d == '1) || (shift_d > MAX_LEFT_SHIFT);

    // Zero and denormals, and values shifted out completely
    assign zero_d = (exp_d == '0) || (shift_d <= -(MANT_WIDTH + 1));

    logic                          sign_q;
    logic [MANT_WIDTH:0]           mant_q;
    logic signed [SHIFT_WIDTH-1:0] shift_q;
    logic                          overflow_q;
    logic                          zero_q;

    always_ff @(posedge aclk)
    begin
        sign_q     <= sign_d;
        mant_q     <= mant_d;
        shift_q    <= shift_d;
        overflow_q <= overflow_d;
        zero_q     <= zero_d;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 shift, negate and saturate
    ////////////////////////////////////////////////////////////
    logic [SHIFT_WIDTH-1:0] right_amount;
    logic [FIXED_SIZE-1:0]  magnitude;
    logic [FIXED_SIZE-1:0]  result;

    assign right_amount = SHIFT_WIDTH'(-shift_q);

    always_comb
    begin
        if (shift_q >= 0)
        begin
            magnitude = FIXED_SIZE'(mant_q) << shift_q;
        end
        else
        begin
            // Dropping the low bits truncates toward zero
            magnitude = FIXED_SIZE'(mant_q) >> right_amount;
        end
    end

    always_comb
    begin
        if (overflow_q)
        begin
            result = sign_q ? FIXED_MIN : FIXED_MAX;
        end
        else if (zero_q)
        begin
            result = '0;
        end
        else if (sign_q)
        begin
            result = -magnitude;
        end
        else
        begin
            result = magnitude;
        end
    end

    always_ff @(posedge aclk)
    begin
        out_fixed <= result;
    end

    // Saturated output keeps the sign of the input
    assert_overflow_sign: assert property (
        @(posedge aclk) overflow_q |=>
            (out_fixed[FIXED_SIZE-1] == $past(in_float[FLOAT_SIZE-1], 2))
    );

endmodule

//--- source/value_delay.sv
// Resettable register chain delaying a value by a fixed number of clocks
`timescale 1ns/1ps

module value_delay
#(
    parameter int WIDTH = 1,
    parameter int DELAY = 2
)
(
    input  logic             aclk,
    input  logic             reset,
    input  logic [WIDTH-1:0] in_value,
    output logic [WIDTH-1:0] out_value
);

    logic [WIDTH-1:0] stages [DELAY];

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DELAY; i++)
            begin
                stages[i] <= '0;
            end
        end
        else
        begin
            stages[0] <= in_value;
            // Shift toward the output
            for (int i = 1; i < DELAY; i++)
            begin
                stages[i] <= stages[i - 1];
            end
        end
    end

    assign out_value = stages[DELAY - 1];

endmodule

//--- source/attribute_f2x_converter.sv
// Converts the float attributes of a fragment into pixel pipeline fixed formats
`timescale 1ns/1ps

module attribute_f2x_converter
    import attribute_pkg::*;
(
    input  logic            aclk,
    input  logic            reset,
    input  logic            in_valid,
    input  fragment_float_t in_frag,
    output logic            out_valid,
    output fragment_fixed_t out_frag
);

    // Anything with integer bits set clamps to 1.0
    function automatic logic [SUB_PIXEL_WIDTH-1:0] saturate_color(
        input logic [FIXED_SIZE-1:0] value
    );
        if (|value[FIXED_SIZE-1:COLOR_FRAC])
        begin
            return '1;
        end
        return value[COLOR_FRAC-SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
    endfunction

    ////////////////////////////////////////////////////////////
    // Pass-through fields
    ////////////////////////////////////////////////////////////
    value_delay #(.WIDTH(1), .DELAY(CONV_DELAY)) valid_delay_inst (
        .aclk(aclk), .reset(reset), .in_value(in_valid), .out_value(out_valid)
    );
    value_delay #(.WIDTH(1), .DELAY(CONV_DELAY)) last_delay_inst (
        .aclk(aclk), .reset(reset), .in_value(in_frag.last), .out_value(out_frag.last)
    );
    value_delay #(.WIDTH(KEEP_WIDTH), .DELAY(CONV_DELAY)) keep_delay_inst (
        .aclk(aclk), .reset(reset), .in_value(in_frag.keep), .out_value(out_frag.keep)
    );
    value_delay #(.WIDTH(SCREEN_POS_WIDTH), .DELAY(CONV_DELAY)) spx_delay_inst (
        .aclk(aclk), .reset(reset), .in_value(in_frag.spx), .out_value(out_frag.spx)
    );
    value_delay #(.WIDTH(SCREEN_POS_WIDTH), .DELAY(CONV_DELAY)) spy_delay_inst (
        .aclk(aclk), .reset(reset), .in_value(in_frag.spy), .out_value(out_frag.spy)
    );
    value_delay #(.WIDTH(INDEX_WIDTH), .DELAY(CONV_DELAY)) index_delay_inst (
        .aclk(aclk), .reset(reset), .in_value(in_frag.index), .out_value(out_frag.index)
    );
    // Depth w is used as a float further down
    value_delay #(.WIDTH(FLOAT_SIZE), .DELAY(CONV_DELAY)) depth_w_delay_inst (
        .aclk(aclk), .reset(reset), .in_value(in_frag.depth_w), .out_value(out_frag.depth_w)
    );

    ////////////////////////////////////////////////////////////
    // Depth z and texture coordinates
    ////////////////////////////////////////////////////////////
    float_to_fixed #(.FRAC(DEPTH_FRAC)) depth_z_inst (
        .aclk(aclk), .in_float(in_frag.depth_z), .out_fixed(out_frag.depth_z)
    );

    // TMU0
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu0_texture_s_inst (
        .aclk(aclk), .in_float(in_frag.tmu0.texture_s), .out_fixed(out_frag.tmu0.texture_s)
    );
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu0_texture_t_inst (
        .aclk(aclk), .in_float(in_frag.tmu0.texture_t), .out_fixed(out_frag.tmu0.texture_t)
    );
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu0_mipmap_s_inst (
        .aclk(aclk), .in_float(in_frag.tmu0.mipmap_s), .out_fixed(out_frag.tmu0.mipmap_s)
    );
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu0_mipmap_t_inst (
        .aclk(aclk), .in_float(in_frag.tmu0.mipmap_t), .out_fixed(out_frag.tmu0.mipmap_t)
    );

    // TMU1
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu1_texture_s_inst (
        .aclk(aclk), .in_float(in_frag.tmu1.texture_s), .out_fixed(out_frag.tmu1.texture_s)
    );
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu1_texture_t_inst (
        .aclk(aclk), .in_float(in_frag.tmu1.texture_t), .out_fixed(out_frag.tmu1.texture_t)
    );
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu1_mipmap_s_inst (
        .aclk(aclk), .in_float(in_frag.tmu1.mipmap_s), .out_fixed(out_frag.tmu1.mipmap_s)
    );
    float_to_fixed #(.FRAC(TEX_FRAC)) tmu1_mipmap_t_inst (
        .aclk(aclk), .in_float(in_frag.tmu1.mipmap_t), .out_fixed(out_frag.tmu1.mipmap_t)
    );

    ////////////////////////////////////////////////////////////
    // Colours
    ////////////////////////////////////////////////////////////
    logic [FLOAT_SIZE-1:0]        color_float [4];
    logic signed [FIXED_SIZE-1:0] color_q16   [4];

    // Channel order r, g, b, a
    assign color_float[0] = in_frag.color.r;
    assign color_float[1] = in_frag.color.g;
    assign color_float[2] = in_frag.color.b;
    assign color_float[3] = in_frag.color.a;

    for (genvar c = 0; c < 4; c++)
    begin : g_color
        float_to_fixed #(.FRAC(COLOR_FRAC)) color_inst (
            .aclk(aclk), .in_float(color_float[c]), .out_fixed(color_q16[c])
        );
    end

    // Negative values have the upper bits set and clamp as well
    assign out_frag.color.r = saturate_color(color_q16[0]);
    assign out_frag.color.g = saturate_color(color_q16[1]);
    assign out_frag.color.b = saturate_color(color_q16[2]);
    assign out_frag.color.a = saturate_color(color_q16[3]);

    // Output strobe follows the input strobe after the pipeline depth
    assert_valid_latency: assert property (
        @(posedge aclk) disable iff (reset)
        (!$past(reset, 1) && !$past(reset, 2)) |-> (out_valid == $past(in_valid, CONV_DELAY))
    );

endmodule

//--- source/fragment_convert_top.sv
// Top level of the fragment attribute conversion subsystem
`timescale 1ns/1ps

module fragment_convert_top
    import attribute_pkg::*;
(
    input  logic            aclk,
    input  logic            reset,

    // Fragment stream from the rasterizer
    input  logic            in_valid,
    input  fragment_float_t in_frag,

    // Fixed-point fragment stream to the pixel pipeline
    output logic            out_valid,
    output fragment_fixed_t out_frag
);

    logic            conv_valid;
    fragment_fixed_t conv_frag;

    attribute_f2x_converter attribute_f2x_converter_inst (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_frag   (in_frag),
        .out_valid (conv_valid),
        .out_frag  (conv_frag)
    );

    assign out_valid = conv_valid;
    assign out_frag  = conv_frag;

endmodule

//--- bench/clock_gen.sv
// Free-running clock source of the attribute converter testbench
`timescale 1ns/1ps

module clock_gen
#(
    parameter real PERIOD = 100.0
)
(
    output logic aclk
);

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #(PERIOD / 2.0) aclk = ~aclk;
        end
    end

endmodule

//--- bench/attribute_tb.sv
// Testbench of the fragment attribute converter with directed and random fragments
`timescale 1ns/1ps

module attribute_tb
    import attribute_pkg::*;
();

    localparam int RESET_CYCLES  = 3;
    localparam int EXACT_COUNT   = 1;
    localparam int SPECIAL_COUNT = 2;
    localparam int STREAM_LEN    = 200;
    localparam int GAP_LEN       = 160;
    localparam int DRAIN_CYCLES  = 4;
    localparam int TEST_COUNT    = 4;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + 2 + EXACT_COUNT + SPECIAL_COUNT
                                 + STREAM_LEN + GAP_LEN + TEST_COUNT * DRAIN_CYCLES + 20;

    logic            aclk;
    logic            reset;
    logic            in_valid;
    fragment_float_t in_frag;
    logic            out_valid;
    fragment_fixed_t out_frag;

    integer          seed;
    int              cycle_count = 0;
    logic [1:0]      valid_hist = '0;
    fragment_fixed_t expected_q [$];

    clock_gen #(.PERIOD(100.0)) clock_gen_inst (.aclk(aclk));

    fragment_convert_top fragment_convert_top_inst (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_frag   (in_frag),
        .out_valid (out_valid),
        .out_frag  (out_frag)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    // Value times 2^frac, truncated toward zero, saturated by sign
    function automatic logic [31:0] expected_fixed(input logic [31:0] f, input int frac);
        logic   sign;
        int     exponent;
        int     shift;
        longint mant;
        longint mag;
        sign     = f[31];
        exponent = int'(f[30:23]);
        mant     = longint'({1'b1, f[22:0]});
        shift    = exponent - 150 + frac;
        if (exponent == 255)
        begin
            return sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
        end
        if (exponent == 0)
        begin
            return '0;
        end
        if (shift > 31)
        begin
            mag = 64'h1_0000_0000;
        end
        else if (shift >= 0)
        begin
            mag = mant << shift;
        end
        else if (shift < -31)
        begin
            mag = 0;
        end
        else
        begin
            mag = mant >> (-shift);
        end
        if (mag > 64'h7FFF_FFFF)
        begin
            return sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
        end
        return sign ? -mag[31:0] : mag[31:0];
    endfunction

    function automatic logic [SUB_PIXEL_WIDTH-1:0] expected_color(input logic [31:0] f);
        logic [31:0] q;
        q = expected_fixed(f, COLOR_FRAC);
        // Integer part set, negatives included
        if (q[31:16] != '0)
        begin
            return '1;
        end
        return q[15:8];
    endfunction

    function automatic fragment_fixed_t expected_fragment(input fragment_float_t f);
        fragment_fixed_t e;
        e.last    = f.last;
        e.keep    = f.keep;
        e.spx     = f.spx;
        e.spy     = f.spy;
        e.index   = f.index;
        e.depth_w = f.depth_w;
        e.depth_z = expected_fixed(f.depth_z, DEPTH_FRAC);
        e.tmu0    = '{expected_fixed(f.tmu0.texture_s, TEX_FRAC),
                      expected_fixed(f.tmu0.texture_t, TEX_FRAC),
                      expected_fixed(f.tmu0.mipmap_s, TEX_FRAC),
                      expected_fixed(f.tmu0.mipmap_t, TEX_FRAC)};
        e.tmu1    = '{expected_fixed(f.tmu1.texture_s, TEX_FRAC),
                      expected_fixed(f.tmu1.texture_t, TEX_FRAC),
                      expected_fixed(f.tmu1.mipmap_s, TEX_FRAC),
                      expected_fixed(f.tmu1.mipmap_t, TEX_FRAC)};
        e.color   = '{expected_color(f.color.r), expected_color(f.color.g),
                      expected_color(f.color.b), expected_color(f.color.a)};
        return e;
    endfunction

    // Random sign and mantissa, exponent in a chosen window
    function automatic logic [31:0] random_float(input int exp_base, input int exp_mask);
        logic [31:0] r;
        logic [7:0]  e;
        r = $random(seed);
        e = 8'(exp_base) + (r[30:23] & 8'(exp_mask));
        return {r[31], e, r[22:0]};
    endfunction

    function automatic fragment_float_t random_fragment();
        fragment_float_t f;
        logic [31:0]     r;
        r         = $random(seed);
        f.last    = r[0];
        f.keep    = r[1 +: KEEP_WIDTH];
        f.spx     = r[12:2];
        f.spy     = r[23:13];
        f.index   = $random(seed);
        f.depth_w = $random(seed);
        f.depth_z = random_float(105, 31);
        f.tmu0    = '{random_float(100, 63), random_float(100, 63),
                      random_float(100, 63), random_float(100, 63)};
        f.tmu1    = '{random_float(100, 63), random_float(100, 63),
                      random_float(100, 63), random_float(100, 63)};
        f.color   = '{random_float(118, 15), random_float(118, 15),
                      random_float(118, 15), random_float(118, 15)};
        return f;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checking and driving
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic compare_fragment(input fragment_fixed_t exp, input fragment_fixed_t act);
        check_value("last", 32'(exp.last), 32'(act.last));
        check_value("keep", 32'(exp.keep), 32'(act.keep));
        check_value("spx", 32'(exp.spx), 32'(act.spx));
        check_value("spy", 32'(exp.spy), 32'(act.spy));
        check_value("index", exp.index, act.index);
        check_value("depth_w", exp.depth_w, act.depth_w);
        check_value("depth_z", exp.depth_z, act.depth_z);
        check_value("tmu0.texture_s", exp.tmu0.texture_s, act.tmu0.texture_s);
        check_value("tmu0.texture_t", exp.tmu0.texture_t, act.tmu0.texture_t);
        check_value("tmu0.mipmap_s", exp.tmu0.mipmap_s, act.tmu0.mipmap_s);
        check_value("tmu0.mipmap_t", exp.tmu0.mipmap_t, act.tmu0.mipmap_t);
        check_value("tmu1.texture_s", exp.tmu1.texture_s, act.tmu1.texture_s);
        check_value("tmu1.texture_t", exp.tmu1.texture_t, act.tmu1.texture_t);
        check_value("tmu1.mipmap_s", exp.tmu1.mipmap_s, act.tmu1.mipmap_s);
        check_value("tmu1.mipmap_t", exp.tmu1.mipmap_t, act.tmu1.mipmap_t);
        check_value("color.r", 32'(exp.color.r), 32'(act.color.r));
        check_value("color.g", 32'(exp.color.g), 32'(act.color.g));
        check_value("color.b", 32'(exp.color.b), 32'(act.color.b));
        check_value("color.a", 32'(exp.color.a), 32'(act.color.a));
    endtask

    task automatic drive_fragment(input logic valid, input fragment_float_t frag,
                                  input fragment_fixed_t expected);
        @(posedge aclk);
        #1;
        in_valid = valid;
        in_frag  = frag;
        if (valid)
        begin
            expected_q.push_back(expected);
        end
    endtask

    task automatic drive_modeled(input logic valid, input fragment_float_t frag);
        drive_fragment(valid, frag, expected_fragment(frag));
    endtask

    task automatic wait_drain();
        @(posedge aclk);
        #1;
        in_valid = 1'b0;
        // Last fragment leaves the pipeline CONV_DELAY clocks later
        repeat (CONV_DELAY) @(posedge aclk);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    // Strobe held high during reset must not leak through
    task automatic apply_reset();
        reset    = 1'b1;
        in_valid = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        reset    = 1'b0;
        in_valid = 1'b0;
        repeat (2)
        begin
            @(negedge aclk);
            check_value("out_valid after reset", '0, 32'(out_valid));
        end
    endtask

    task automatic test_exact_values();
        fragment_float_t f;
        fragment_fixed_t e;
        f = random_fragment();
        f.depth_z = 32'h3E80_0000;
        f.tmu0    = '{32'h3FC0_0000, 32'hC000_0000, 32'h3F40_0000, 32'hBFC0_0000};
        f.tmu1    = '{32'h42C8_0000, 32'h0000_0000, 32'h4040_0000, 32'hBF00_0000};
        f.color   = '{32'h3F00_0000, 32'h3E80_0000, 32'h0000_0000, 32'h3F40_0000};
        e.last    = f.last;
        e.keep    = f.keep;
        e.spx     = f.spx;
        e.spy     = f.spy;
        e.index   = f.index;
        e.depth_w = f.depth_w;
        // 0.25 in Q16.16, then 1.5 -2.0 0.75 -1.5 and 100 0 3 -0.5 in S16.15
        e.depth_z = 32'h0000_4000;
        e.tmu0    = '{32'h0000_C000, 32'hFFFF_0000, 32'h0000_6000, 32'hFFFF_4000};
        e.tmu1    = '{32'h0032_0000, 32'h0000_0000, 32'h0001_8000, 32'hFFFF_C000};
        e.color   = '{8'h80, 8'h40, 8'h00, 8'hC0};
        drive_fragment(1'b1, f, e);
    endtask

    task automatic test_special_values();
        fragment_float_t f;
        // Overflow, infinity and NaN of both signs, colours at or above 1.0 and negative
        f = random_fragment();
        f.depth_z = 32'h4780_0000;
        f.tmu0    = '{32'h4788_B800, 32'h7F80_0000, 32'h7FC0_0000, 32'h4780_0000};
        f.tmu1    = '{32'hC788_B800, 32'hFF80_0000, 32'hFFC0_0000, 32'hC780_0000};
        f.color   = '{32'h3F80_0000, 32'h4000_0000, 32'hBF00_0000, 32'h7F80_0000};
        drive_modeled(1'b1, f);
        // Denormals, signed zeros and values near the last fraction bit
        f = random_fragment();
        f.depth_z = 32'h0000_0001;
        f.tmu0    = '{32'h007F_FFFF, 32'h8000_0001, 32'h0000_0000, 32'h8000_0000};
        f.tmu1    = '{32'h3380_0000, 32'hB380_0000, 32'h3800_0000, 32'hB800_0000};
        f.color   = '{32'h0040_0000, 32'h3F7F_FFFF, 32'h3B80_0000, 32'h8000_0000};
        drive_modeled(1'b1, f);
    endtask

    task automatic test_stream();
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            drive_modeled(1'b1, random_fragment());
        end
    endtask

    task automatic test_gaps();
        logic [31:0] r;
        for (int i = 0; i < GAP_LEN; i++)
        begin
            r = $random(seed);
            drive_modeled(r[0], random_fragment());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor and timeout
    ////////////////////////////////////////////////////////////
    always @(posedge aclk)
    begin
        if (reset)
        begin
            valid_hist <= '0;
        end
        else
        begin
            valid_hist <= {valid_hist[0], in_valid};
        end
    end

    // Sampled mid-cycle, away from both the clock edge and the drive time
    always @(negedge aclk)
    begin
        check_value("out_valid", 32'(valid_hist[1]), 32'(out_valid));
        if (out_valid && expected_q.size() == 0)
        begin
            $display("Output fragment at %0t with none expected", $time);
            $display("Something failed");
            $fatal(1, "Unexpected output fragment");
        end
        else if (out_valid)
        begin
            compare_fragment(expected_q.pop_front(), out_frag);
        end
    end

    always @(posedge aclk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles", cycle_count);
            $display("Something failed");
            $fatal(1, "Run did not finish in time");
        end
    end

    initial
    begin
        seed     = 32'h93ec;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_frag  = '0;
        apply_reset();
        test_exact_values();
        wait_drain();
        test_special_values();
        wait_drain();
        test_stream();
        wait_drain();
        test_gaps();
        wait_drain();
        if (expected_q.size() != 0)
        begin
            $display("%0d expected fragments never came out", expected_q.size());
            $display("Something failed");
            $fatal(1, "Expected queue not empty");
        end
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- flist.f
source/attribute_pkg.sv
source/float_to_fixed.sv
source/value_delay.sv
source/attribute_f2x_converter.sv
source/fragment_convert_top.sv
bench/clock_gen.sv
bench/attribute_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the attribute converter testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -sv \
    -f flist.f \
    --top-module attribute_tb \
    -Mdir "$BUILD_DIR" \
    -o attribute_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/attribute_tb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

echo "Simulation passed"
exit 0
